/* hdl/booth_cfg_pkg.sv */
`default_nettype none

package booth_cfg_pkg;

  // operand width, both a and b
  localparam int op_width = 16;

  // full signed product
  localparam int prod_width = 2 * op_width;

  // accumulator carries one guard bit above the multiplicand
  localparam int acc_width = op_width + 1;

  // iteration counter must reach op_width itself
  localparam int count_width = $clog2(op_width + 1);

  localparam logic [count_width-1:0] last_count = count_width'(op_width - 1); // final step
  localparam logic [count_width-1:0] max_count  = count_width'(op_width);     // after final step

endpackage

`default_nettype wire

/* hdl/booth_types_pkg.sv */
`default_nettype none

package booth_types_pkg;

  // recode operation for one bit pair {mult[0], prev}
  localparam logic [1:0] op_none = 2'b00;
  localparam logic [1:0] op_add  = 2'b01;
  localparam logic [1:0] op_sub  = 2'b10;

  // control states
  localparam logic [1:0] st_idle   = 2'b00;
  localparam logic [1:0] st_run    = 2'b01;
  localparam logic [1:0] st_finish = 2'b10;

  // shift register word, seen either as one vector or as its fields
  typedef union packed {
    logic [booth_cfg_pkg::acc_width + booth_cfg_pkg::op_width:0] raw; // whole word, shifted as one
    struct packed {
      logic [booth_cfg_pkg::acc_width-1:0] acc;  // partial product, high part
      logic [booth_cfg_pkg::op_width-1:0]  mult; // multiplier in, product low half out
      logic                                prev; // bit shifted out below mult
    } fld;
  } booth_word_u;

endpackage

`default_nettype wire

/* hdl/booth_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_ctrl (
  input  wire  clk,
  input  wire  rst,
  input  wire  start,
  output logic load,
  output logic step,
  output logic busy,
  output logic done
);

  logic [1:0] state;
  logic [1:0] state_next;
  logic [booth_cfg_pkg::count_width-1:0] cnt;
  logic last_step;

  assign load = start && (state == booth_types_pkg::st_idle); // start ignored while busy
  assign step = (state == booth_types_pkg::st_run);
  assign busy = (state != booth_types_pkg::st_idle);
  assign last_step = step && (cnt == booth_cfg_pkg::last_count);

  always_comb begin
    state_next = state;
    case (state)
      booth_types_pkg::st_idle: begin
        if (load) begin
          state_next = booth_types_pkg::st_run;
        end
      end
      booth_types_pkg::st_run: begin
        if (last_step) begin
          state_next = booth_types_pkg::st_finish;
        end
      end
      booth_types_pkg::st_finish: begin
        state_next = booth_types_pkg::st_idle;
      end
      default: begin
        state_next = booth_types_pkg::st_idle; // unused code, recover
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= booth_types_pkg::st_idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= (state == booth_types_pkg::st_finish); // one cycle after the last update
      if (load) begin
        cnt <= '0;
      end else if (step) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // done is a lone pulse, never overlapping an iteration
  a_done_not_step: assert property (
    @(posedge clk) disable iff (rst) !(done && step)
  ) else $error("done and step high together");

  // busy has already dropped by the time the result is flagged
  a_done_not_busy: assert property (
    @(posedge clk) disable iff (rst) done |-> !busy
  ) else $error("done while busy");

  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst) cnt <= booth_cfg_pkg::max_count
  ) else $error("iteration counter out of range");

endmodule

`default_nettype wire

/* hdl/booth_addend_sel.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_addend_sel (
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire                                        load,
  input  wire signed [booth_cfg_pkg::op_width-1:0]   b,
  input  wire        [1:0]                           pair,
  output logic       [booth_cfg_pkg::acc_width-1:0]  addend,
  output logic       [1:0]                           op
);

  logic signed [booth_cfg_pkg::acc_width-1:0] b_ext;
  logic        [booth_cfg_pkg::acc_width-1:0] mcand;
  logic        [booth_cfg_pkg::acc_width-1:0] mcand_neg;

  assign b_ext = b; // sign extend first, so -b of the most negative value fits

  always_ff @(posedge clk) begin
    if (rst) begin
      mcand     <= '0;
      mcand_neg <= '0;
    end else if (load) begin
      mcand     <= b_ext;
      mcand_neg <= -b_ext;
    end
  end

  always_comb begin
    case (pair)
      2'b10: begin // start of a run of ones
        op     = booth_types_pkg::op_sub;
        addend = mcand_neg;
      end
      2'b01: begin // end of a run of ones
        op     = booth_types_pkg::op_add;
        addend = mcand;
      end
      default: begin
        op     = booth_types_pkg::op_none;
        addend = '0;
      end
    endcase
  end

  // negation keeps the opposite sign even for the most negative b
  a_neg_sign: assert property (
    @(posedge clk) disable iff (rst)
      (mcand != '0)
        |-> (mcand[booth_cfg_pkg::acc_width-1] != mcand_neg[booth_cfg_pkg::acc_width-1])
  ) else $error("negated multiplicand has the wrong sign");

endmodule

`default_nettype wire

/* hdl/booth_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_accum (
  input  wire                                       clk,
  input  wire                                       rst,
  input  wire                                       load,
  input  wire                                       step,
  input  wire signed [booth_cfg_pkg::op_width-1:0]  a,
  input  wire        [booth_cfg_pkg::acc_width-1:0] addend,
  input  wire        [1:0]                          op,
  output booth_types_pkg::booth_word_u              word
);

  logic [booth_cfg_pkg::acc_width-1:0] acc_sum;
  booth_types_pkg::booth_word_u        added;
  booth_types_pkg::booth_word_u        shifted;
  booth_types_pkg::booth_word_u        loaded;

  // fresh word: acc clear, multiplier in the low part, no bit below it
  always_comb begin
    loaded.fld.acc  = '0;
    loaded.fld.mult = a;
    loaded.fld.prev = 1'b0;
  end

  // add stage, acc only
  always_comb begin
    if (op == booth_types_pkg::op_none) begin
      acc_sum = word.fld.acc;
    end else begin
      acc_sum = word.fld.acc + addend; // guard bit keeps this exact
    end
  end

  always_comb begin
    added.fld.acc  = acc_sum;
    added.fld.mult = word.fld.mult;
    added.fld.prev = word.fld.prev;
  end

  // shift stage, whole word as one signed vector
  assign shifted.raw = $signed(added.raw) >>> 1; // mult[0] drops into prev

  always_ff @(posedge clk) begin
    if (rst) begin
      word.raw <= '0;
    end else if (load) begin
      word <= loaded;
    end else if (step) begin
      word <= shifted;
    end
  end

  // the guard bit keeps every Booth add from wrapping
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
      (step && (op != booth_types_pkg::op_none)
        && (word.fld.acc[booth_cfg_pkg::acc_width-1] == addend[booth_cfg_pkg::acc_width-1]))
      |-> (acc_sum[booth_cfg_pkg::acc_width-1] == addend[booth_cfg_pkg::acc_width-1])
  ) else $error("accumulator add overflowed");

endmodule

`default_nettype wire

/* hdl/booth_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_mul_top (
  input  wire                                         clk,
  input  wire                                         rst,
  input  wire                                         start,
  input  wire signed   [booth_cfg_pkg::op_width-1:0]   a,
  input  wire signed   [booth_cfg_pkg::op_width-1:0]   b,
  output logic signed  [booth_cfg_pkg::prod_width-1:0] product,
  output logic                                        busy,
  output logic                                        done
);

  logic                                load;
  logic                                step;
  logic [1:0]                          pair;
  logic [1:0]                          op;
  logic [booth_cfg_pkg::acc_width-1:0] addend;
  booth_types_pkg::booth_word_u        word;

  booth_ctrl u_ctrl (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .load  (load),
    .step  (step),
    .busy  (busy),
    .done  (done)
  );

  booth_addend_sel u_addend_sel (
    .clk    (clk),
    .rst    (rst),
    .load   (load),
    .b      (b),
    .pair   (pair),
    .addend (addend),
    .op     (op)
  );

  booth_accum u_accum (
    .clk    (clk),
    .rst    (rst),
    .load   (load),
    .step   (step),
    .a      (a),
    .addend (addend),
    .op     (op),
    .word   (word)
  );

  assign pair = {word.fld.mult[0], word.fld.prev}; // current Booth bit pair

  // guard bit dropped, the exact product fits in prod_width
  assign product = {word.fld.acc[booth_cfg_pkg::op_width-1:0], word.fld.mult};

endmodule

`default_nettype wire

/* tests/booth_mul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_mul_tb;

  localparam int width         = booth_cfg_pkg::op_width;
  localparam int clk_period    = 20;
  localparam int reset_cycles  = 10;
  localparam int n_corner      = 16;
  localparam int n_random      = 200;
  localparam int n_tests       = n_corner + n_random + 1; // corners, random, busy start
  localparam int margin_cycles = 1000;
  localparam int watchdog_ns   =
    (n_tests * (width + 4) + reset_cycles + margin_cycles) * clk_period;

  localparam logic [31:0] lfsr_taps = 32'ha3000000; // x^32 + x^30 + x^26 + x^25 + 1

  localparam logic signed [width-1:0] max_pos = {1'b0, {(width-1){1'b1}}};
  localparam logic signed [width-1:0] max_neg = {1'b1, {(width-1){1'b0}}};
  localparam logic signed [width-1:0] one     = 1;
  localparam logic signed [width-1:0] neg_one = -1;

  logic                                         clk = 1'b0;
  logic                                         rst;
  logic                                         start;
  logic signed [width-1:0]                      a;
  logic signed [width-1:0]                      b;
  logic signed [booth_cfg_pkg::prod_width-1:0]  product;
  logic                                         busy;
  logic                                         done;

  logic [31:0] lfsr = 32'h2d64;
  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          results = 0;

  // operands of accepted starts, oldest first
  logic signed [width-1:0] a_q[$];
  logic signed [width-1:0] b_q[$];
  int                      sampled_q[$]; // edge that sampled start

  logic signed [width-1:0]                     mon_a;
  logic signed [width-1:0]                     mon_b;
  int                                          mon_edge;
  logic signed [booth_cfg_pkg::prod_width-1:0] held_product = '0;
  logic                                        hold_valid = 1'b0;
  logic                                        done_last = 1'b0;

  logic signed [width-1:0] ra;
  logic signed [width-1:0] rb;
  int                      first_edge;

  booth_mul_top dut (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .a       (a),
    .b       (b),
    .product (product),
    .busy    (busy),
    .done    (done)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ lfsr_taps;
    end
    return next;
  endfunction

  // full signed product, both operands widened first
  function automatic logic signed [booth_cfg_pkg::prod_width-1:0] ref_product(
    input logic signed [width-1:0] x,
    input logic signed [width-1:0] y
  );
    logic signed [booth_cfg_pkg::prod_width-1:0] xe;
    logic signed [booth_cfg_pkg::prod_width-1:0] ye;
    xe = x;
    ye = y;
    return xe * ye;
  endfunction

  task automatic random_operand(output logic signed [width-1:0] value);
    for (int i = 0; i < width; i++) begin
      lfsr = lfsr_step(lfsr);
      value[i] = lfsr[0];
    end
  endtask

  task automatic check_value(
    input string              name,
    input logic signed [63:0] expected,
    input logic signed [63:0] actual
  );
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  // call on a falling edge with busy low
  task automatic issue_start(input logic signed [width-1:0] x, input logic signed [width-1:0] y);
    a = x;
    b = y;
    start = 1'b1;
    a_q.push_back(x);
    b_q.push_back(y);
    sampled_q.push_back(cycle + 1);
    @(negedge clk);
    start = 1'b0;
    a = ~x; // operands only valid with start
    b = ~y;
  endtask

  task automatic pulse_ignored_start(
    input logic signed [width-1:0] x,
    input logic signed [width-1:0] y
  );
    a = x;
    b = y;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    a = '0;
    b = '0;
  endtask

  task automatic wait_done();
    while (!done) begin
      @(negedge clk);
    end
  endtask

  task automatic run_mul(
    input logic signed [width-1:0] x,
    input logic signed [width-1:0] y,
    input int                      idle
  );
    issue_start(x, y);
    wait_done();
    repeat (idle) @(negedge clk);
  endtask

  // compare process, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (done) begin
        if (done_last) begin
          report_error("done stayed high for more than one cycle");
        end else if (a_q.size() == 0) begin
          report_error("done pulsed with no multiplication pending");
        end else begin
          mon_a = a_q.pop_front();
          mon_b = b_q.pop_front();
          mon_edge = sampled_q.pop_front();
          check_value("product", ref_product(mon_a, mon_b), product);
          check_value("latency", width + 1, cycle - mon_edge);
          check_value("busy", 0, busy);
          held_product = product;
          hold_valid = 1'b1;
          results++;
        end
      end else if (a_q.size() == 0) begin
        check_value("busy", 0, busy); // idle
        if (hold_valid) begin
          check_value("product", held_product, product);
        end
      end else if (cycle >= sampled_q[0]) begin
        check_value("busy", 1, busy);
      end
    end
    done_last = done;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: done never arrived, run stopped after %0d ns", watchdog_ns);
    $display("summary: %0d products, %0d checks, %0d errors", results, checks, errors + 1);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst = 1'b1;
    start = 1'b0;
    a = '0;
    b = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("product", 0, product);

    // corner operands, idle gaps exercise the product hold
    run_mul(0, 12345, 5);
    run_mul(0, max_neg, 5);
    run_mul(max_neg, 0, 5);
    run_mul(one, one, 5);
    run_mul(one, neg_one, 5);
    run_mul(neg_one, neg_one, 5);
    run_mul(one, max_pos, 5);
    run_mul(max_pos, max_pos, 5);
    run_mul(max_neg, one, 5);
    run_mul(max_neg, neg_one, 5);
    run_mul(one, max_neg, 5);
    run_mul(neg_one, max_neg, 5);
    run_mul(max_neg, max_neg, 5);
    run_mul(1234, -567, 5);
    run_mul(-300, 25, 5);
    run_mul(max_pos, max_neg, 5);

    for (int i = 0; i < n_random; i++) begin
      random_operand(ra);
      random_operand(rb);
      run_mul(ra, rb, (i % 4 == 0) ? 0 : 1); // some back to back
    end

    // starts during the run and in the finishing cycle must be dropped
    first_edge = cycle + 1;
    issue_start(-1234, 4321);
    repeat (4) @(negedge clk);
    pulse_ignored_start(777, -999);
    while (cycle < first_edge + width) begin
      @(negedge clk);
    end
    pulse_ignored_start(max_neg, max_neg);
    wait_done();
    repeat (width + 4) @(negedge clk);

    if (a_q.size() != 0) begin
      report_error($sformatf("%0d products never arrived", a_q.size()));
    end

    $display("summary: %0d products, %0d checks, %0d errors", results, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/booth_cfg_pkg.sv
hdl/booth_types_pkg.sv
hdl/booth_ctrl.sv
hdl/booth_addend_sel.sv
hdl/booth_accum.sv
hdl/booth_mul_top.sv
tests/booth_mul_tb.sv

/* Makefile */
# Verilator build and run of the Booth multiplier testbench

VERILATOR ?= verilator
TOP       ?= booth_mul_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
